//--- list.f
src/bcdPkg.sv
src/binToBcd.sv
src/bcdAddDatapath.sv
src/bcdAddSequencer.sv
src/bcdAdder.sv
testbench/bcdAdderTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f list.f --top-module bcdAdderTb -o bcdAdderSim \
    && ./obj_dir/bcdAdderSim | tee /dev/stderr | grep -q "sim passed" \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }

//--- testbench/bcdAdderTb.sv
`timescale 1ns/1ps

module bcdAdderTb;

    import bcdPkg::*;

    localparam int TIMEOUT_CYCLES = 20;

    logic       CLK;
    logic       rstN;
    logic [7:0] inData;
    bcdOp       cmd;
    logic       cmdValid;
    logic       busy;
    logic       done;
    logic [7:0] outData;

    bcdAdder i_dut
    (
        .CLK(CLK), .rstN(rstN), .inData(inData), .cmd(cmd), .cmdValid(cmdValid),
        .busy(busy), .done(done), .outData(outData)
    );

    // 20 ns clock
    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stopWithError(input string reason);
        begin
            $display("%s", reason);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
        begin
            if (actual !== expected)
                stopWithError($sformatf("error %s: got 0x%02h, expected 0x%02h",
                                        name, actual, expected));
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected)
        ;
        begin
            if (actual !== expected)
                stopWithError($sformatf("error %s: got 0x%h, expected 0x%h",
                                        name, actual, expected));
        end
    endtask

    // Two decimal digits, tens in the high nibble
    function automatic logic [7:0] decimalPair(input int value);
        int tens;
        int ones;
        begin
            tens = (value / 10) % 10;
            ones = value % 10;
            return 8'(tens * 16 + ones);
        end
    endfunction

    // Strobe one command, wait for done and then for idle
    task automatic issueCmd(input bcdOp op, input logic [7:0] data);
        int waitCount;
        begin
            @(negedge CLK);
            cmd      = op;
            inData   = data;
            cmdValid = 1'b1;
            @(negedge CLK);
            cmdValid = 1'b0;
            waitCount = 0;
            while (done !== 1'b1)
            begin
                if (waitCount >= TIMEOUT_CYCLES)
                    stopWithError("timeout: done never rose after a command");
                @(negedge CLK);
                waitCount++;
            end
            waitCount = 0;
            while (busy !== 1'b0)
            begin
                if (waitCount >= TIMEOUT_CYCLES)
                    stopWithError("timeout: busy stayed high after done");
                @(negedge CLK);
                waitCount++;
            end
        end
    endtask

    task automatic showAndCheck(input bcdOp op, input logic [7:0] expected);
        begin
            issueCmd(op, 8'h00);
            checkByte(op.name(), outData, expected);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testReset();
        begin
            checkBit("busy", busy, 1'b0);
            checkBit("done", done, 1'b0);
            showAndCheck(opShowA, 8'h00);
            showAndCheck(opShowB, 8'h00);
            showAndCheck(opShowLs, 8'h00);
            showAndCheck(opShowMs, 8'h00);
        end
    endtask

    task automatic testLoadShow();
        int a;
        int b;
        begin
            for (int i = 0; i < 8; i++)
            begin
                a = $urandom % 100;
                b = $urandom % 100;
                issueCmd(opLoadA, 8'(a));
                issueCmd(opLoadB, 8'(b));
                showAndCheck(opShowA, decimalPair(a));
                showAndCheck(opShowB, decimalPair(b));
            end
            // Out of range saturates at two digits
            issueCmd(opLoadA, 8'd150);
            showAndCheck(opShowA, decimalPair(int'(OPERAND_MAX)));
            issueCmd(opLoadB, 8'd255);
            showAndCheck(opShowB, decimalPair(int'(OPERAND_MAX)));
        end
    endtask

    task automatic addAndCheck(input int a, input int b);
        int total;
        begin
            total = a + b;
            issueCmd(opLoadA, 8'(a));
            issueCmd(opLoadB, 8'(b));
            issueCmd(opAdd, 8'h00);
            showAndCheck(opShowLs, decimalPair(total % 100));
            showAndCheck(opShowMs, 8'(total / 100));
        end
    endtask

    task automatic testAdd();
        begin
            for (int i = 0; i < 12; i++)
                addAndCheck($urandom % 100, $urandom % 100);
            // Corners
            addAndCheck(99, 99);
            addAndCheck(0, 0);
            addAndCheck(50, 50);
        end
    endtask

    task automatic testInit();
        begin
            addAndCheck(87, 45);
            issueCmd(opInit, 8'h00);
            showAndCheck(opShowA, 8'h00);
            showAndCheck(opShowB, 8'h00);
            showAndCheck(opShowLs, 8'h00);
            showAndCheck(opShowMs, 8'h00);
            issueCmd(opAdd, 8'h00);
            showAndCheck(opShowLs, 8'h00);
            showAndCheck(opShowMs, 8'h00);
        end
    endtask

    // Edge-by-edge view of one command, with a strobe while busy
    task automatic testTiming();
        begin
            @(negedge CLK);
            cmd      = opLoadA;
            inData   = 8'd37;
            cmdValid = 1'b1;
            // Accepting edge passed
            @(negedge CLK);
            checkBit("busy", busy, 1'b1);
            checkBit("done", done, 1'b0);
            // Init strobe while busy must be dropped
            cmd      = opInit;
            cmdValid = 1'b1;
            @(negedge CLK);
            cmdValid = 1'b0;
            checkBit("busy", busy, 1'b1);
            checkBit("done", done, 1'b0);
            // Third edge from the strobe
            @(negedge CLK);
            checkBit("busy", busy, 1'b1);
            checkBit("done", done, 1'b1);
            @(negedge CLK);
            checkBit("busy", busy, 1'b0);
            checkBit("done", done, 1'b0);
            // No second command started
            @(negedge CLK);
            checkBit("busy", busy, 1'b0);
            showAndCheck(opShowA, decimalPair(37));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        rstN     = 1'b0;
        inData   = 8'h00;
        cmd      = opInit;
        cmdValid = 1'b0;
        void'($urandom(32'ha8898fad));
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        rstN = 1'b1;

        testReset();
        testLoadShow();
        testAdd();
        testInit();
        testTiming();

        $display("sim passed");
        $finish;
    end

endmodule

//--- src/bcdAdder.sv
`timescale 1ns/1ps

module bcdAdder
(
    input  logic         CLK,
    input  logic         rstN,
    input  logic [7:0]   inData,
    input  bcdPkg::bcdOp cmd,
    input  logic         cmdValid,
    output logic         busy,
    output logic         done,
    output logic [7:0]   outData
);

    // Request levels, sequencer to datapath
    logic initReq;
    logic loadAReq;
    logic loadBReq;
    logic showAReq;
    logic showBReq;
    logic addReq;
    logic showLsReq;
    logic showMsReq;

    // Ack pulses back
    logic initAck;
    logic loadAAck;
    logic loadBAck;
    logic showAAck;
    logic showBAck;
    logic addAck;
    logic showLsAck;
    logic showMsAck;

    ////////////////////////////////////////////////////////////////////////////
    // Command sequencer
    ////////////////////////////////////////////////////////////////////////////

    bcdAddSequencer i_seq
    (
        .CLK(CLK), .rstN(rstN), .cmd(cmd), .cmdValid(cmdValid),
        .busy(busy), .done(done),
        .initReq(initReq), .loadAReq(loadAReq), .loadBReq(loadBReq),
        .showAReq(showAReq), .showBReq(showBReq), .addReq(addReq),
        .showLsReq(showLsReq), .showMsReq(showMsReq),
        .initAck(initAck), .loadAAck(loadAAck), .loadBAck(loadBAck),
        .showAAck(showAAck), .showBAck(showBAck), .addAck(addAck),
        .showLsAck(showLsAck), .showMsAck(showMsAck)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    bcdAddDatapath i_dp
    (
        .CLK(CLK), .rstN(rstN), .inData(inData),
        .initReq(initReq), .loadAReq(loadAReq), .loadBReq(loadBReq),
        .showAReq(showAReq), .showBReq(showBReq), .addReq(addReq),
        .showLsReq(showLsReq), .showMsReq(showMsReq),
        .initAck(initAck), .loadAAck(loadAAck), .loadBAck(loadBAck),
        .showAAck(showAAck), .showBAck(showBAck), .addAck(addAck),
        .showLsAck(showLsAck), .showMsAck(showMsAck),
        .outData(outData)
    );

endmodule

//--- src/bcdAddSequencer.sv
`timescale 1ns/1ps

module bcdAddSequencer
(
    input  logic        CLK,
    input  logic        rstN,
    input  bcdPkg::bcdOp cmd,
    input  logic        cmdValid,
    output logic        busy,
    output logic        done,
    output logic        initReq,
    output logic        loadAReq,
    output logic        loadBReq,
    output logic        showAReq,
    output logic        showBReq,
    output logic        addReq,
    output logic        showLsReq,
    output logic        showMsReq,
    input  logic        initAck,
    input  logic        loadAAck,
    input  logic        loadBAck,
    input  logic        showAAck,
    input  logic        showBAck,
    input  logic        addAck,
    input  logic        showLsAck,
    input  logic        showMsAck
);

    import bcdPkg::*;

    seqState    state;
    bcdOp       opReg;
    logic [7:0] reqVec;
    logic [7:0] ackVec;

    assign ackVec = {showMsAck, showLsAck, addAck, showBAck,
                     showAAck, loadBAck, loadAAck, initAck};

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= stIdle;
            opReg <= opInit;
        end
        else
        begin
            case (state)
                stIdle:
                begin
                    // Only place a command is taken
                    if (cmdValid)
                    begin
                        opReg <= cmd;
                        state <= stReq;
                    end
                end
                stReq:
                begin
                    // Hold request until its own ack
                    if (ackVec[opReg])
                        state <= stDone;
                end
                default:
                    state <= stIdle;
            endcase
        end
    end

    // One request line, selected by the latched opcode
    assign reqVec = (state == stReq) ? (8'h01 << opReg) : 8'h00;

    assign {showMsReq, showLsReq, addReq, showBReq,
            showAReq, loadBReq, loadAReq, initReq} = reqVec;

    assign busy = (state != stIdle);
    assign done = (state == stDone);

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Acks come only for the pending request
    ackForReq: assert property (@(posedge CLK) disable iff (!rstN)
        (ackVec & ~reqVec) == 8'h00);

    // Datapath answers in one cycle so done lands three edges after acceptance
    doneTiming: assert property (@(posedge CLK) disable iff (!rstN)
        done |-> $past(state == stIdle && cmdValid, 3));

endmodule

//--- src/bcdAddDatapath.sv
`timescale 1ns/1ps

module bcdAddDatapath
(
    input  logic       CLK,
    input  logic       rstN,
    input  logic [7:0] inData,
    input  logic       initReq,
    input  logic       loadAReq,
    input  logic       loadBReq,
    input  logic       showAReq,
    input  logic       showBReq,
    input  logic       addReq,
    input  logic       showLsReq,
    input  logic       showMsReq,
    output logic       initAck,
    output logic       loadAAck,
    output logic       loadBAck,
    output logic       showAAck,
    output logic       showBAck,
    output logic       addAck,
    output logic       showLsAck,
    output logic       showMsAck,
    output logic [7:0] outData
);

    import bcdPkg::*;

    // Request and ack lines packed by opcode index
    logic [7:0] reqVec;
    logic [7:0] ackVec;
    logic [7:0] serve;

    // Binary operands and sum
    logic [7:0] opA;
    logic [7:0] opB;
    logic [7:0] sum;
    logic [7:0] clamped;

    // Decimal digits of each stored value
    logic [3:0] aTens;
    logic [3:0] aOnes;
    logic [3:0] bTens;
    logic [3:0] bOnes;
    logic [3:0] sumHund;
    logic [3:0] sumTens;
    logic [3:0] sumOnes;

    assign reqVec = {showMsReq, showLsReq, addReq, showBReq,
                     showAReq, loadBReq, loadAReq, initReq};

    // Served once; the high ack masks the still-high request next edge
    assign serve = reqVec & ~ackVec;

    // Values above two digits saturate
    assign clamped = (inData > OPERAND_MAX) ? OPERAND_MAX : inData;

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
        begin
            ackVec  <= '0;
            opA     <= '0;
            opB     <= '0;
            sum     <= '0;
            outData <= '0;
        end
        else
        begin
            // One-cycle ack for whatever was served
            ackVec <= serve;
            if (serve[opInit])
            begin
                opA <= '0;
                opB <= '0;
                sum <= '0;
            end
            if (serve[opLoadA])
                opA <= clamped;
            if (serve[opLoadB])
                opB <= clamped;
            if (serve[opAdd])
                sum <= opA + opB;
            if (serve[opShowA])
                outData <= {aTens, aOnes};
            if (serve[opShowB])
                outData <= {bTens, bOnes};
            if (serve[opShowLs])
                outData <= {sumTens, sumOnes};
            if (serve[opShowMs])
                outData <= {4'h0, sumHund};
        end
    end

    assign initAck   = ackVec[opInit];
    assign loadAAck  = ackVec[opLoadA];
    assign loadBAck  = ackVec[opLoadB];
    assign showAAck  = ackVec[opShowA];
    assign showBAck  = ackVec[opShowB];
    assign addAck    = ackVec[opAdd];
    assign showLsAck = ackVec[opShowLs];
    assign showMsAck = ackVec[opShowMs];

    ////////////////////////////////////////////////////////////////////////////
    // Converters
    ////////////////////////////////////////////////////////////////////////////

    // Operands stay below 100 so hundreds is left open
    binToBcd i_aBcd   (.bin(opA), .hundreds(), .tens(aTens), .ones(aOnes));
    binToBcd i_bBcd   (.bin(opB), .hundreds(), .tens(bTens), .ones(bOnes));
    binToBcd i_sumBcd (.bin(sum), .hundreds(sumHund), .tens(sumTens), .ones(sumOnes));

    // Sequencer drives at most one request
    reqOneHot: assert property (@(posedge CLK) disable iff (!rstN) $onehot0(reqVec));

    // A served request stays high one more edge and its ack masks it
    reqHeld: assert property (@(posedge CLK) disable iff (!rstN)
        (serve != 8'h00) |=> ((reqVec & $past(serve)) == $past(serve)));

endmodule

//--- src/binToBcd.sv
`timescale 1ns/1ps

module binToBcd
(
    input  logic [7:0] bin,
    output logic [3:0] hundreds,
    output logic [3:0] tens,
    output logic [3:0] ones
);

    // Digits in [19:8] and binary shifted out of [7:0]
    logic [19:0] shiftReg;

    ////////////////////////////////////////////////////////////////////////////
    // Shift and add 3
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        shiftReg = {12'd0, bin};
        for (int i = 0; i < 8; i++)
        begin
            // Correct any digit of 5 or more before it doubles
            if (shiftReg[11:8] > 4'd4)
            begin
                shiftReg[11:8] = shiftReg[11:8] + 4'd3;
            end
            if (shiftReg[15:12] > 4'd4)
            begin
                shiftReg[15:12] = shiftReg[15:12] + 4'd3;
            end
            // Hundreds needs no correction as it stays at 2 or less
            shiftReg = shiftReg << 1;
        end
    end

    assign hundreds = shiftReg[19:16];
    assign tens     = shiftReg[15:12];
    assign ones     = shiftReg[11:8];

endmodule

//--- src/bcdPkg.sv
package bcdPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Command opcodes
    ////////////////////////////////////////////////////////////////////////////

    // Opcode value doubles as the bit index of its request line
    typedef enum logic [2:0]
    {
        opInit   = 3'd0,
        opLoadA  = 3'd1,
        opLoadB  = 3'd2,
        opShowA  = 3'd3,
        opShowB  = 3'd4,
        opAdd    = 3'd5,
        opShowLs = 3'd6,
        opShowMs = 3'd7
    } bcdOp;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0]
    {
        stIdle = 2'd0,
        stReq  = 2'd1,
        stDone = 2'd2
    } seqState;

    // Two decimal digits per operand
    localparam logic [7:0] OPERAND_MAX = 8'd99;

endpackage
